// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing -j 0 --top-module kr580_tb -f compile.f -o kr580_sim

run: compile
	@out="$$(./obj_dir/kr580_sim)"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: compile.f
+incdir+tb
hw/kr580_pkg.sv
hw/kr580_alu.sv
hw/kr580_regfile.sv
hw/kr580_sequencer.sv
hw/kr580_top.sv
tb/kr580_tb.sv

// File: hw/kr580_alu.sv
`timescale 1ns/10ps

module kr580_alu
    import kr580_pkg::*;
(
    input  alu_op_t op,
    input  byte_t   op1,
    input  byte_t   op2,
    input  byte_t   flags_in,
    output byte_t   result,
    output byte_t   flags_out
);

    logic [8:0] sum;
    logic       carry_in;
    logic       is_sub;
    logic       is_arith;
    logic       overflow;

    assign carry_in = flags_in[flag_cf];

    // Nine bits wide so that bit 8 is carry or borrow
    always_comb begin
        case (op)
            alu_add: begin
                sum = {1'b0, op1} + {1'b0, op2};
            end
            alu_adc: begin
                sum = {1'b0, op1} + {1'b0, op2} + {8'h00, carry_in};
            end
            alu_sub, alu_cp: begin
                sum = {1'b0, op1} - {1'b0, op2};
            end
            alu_sbc: begin
                sum = {1'b0, op1} - {1'b0, op2} - {8'h00, carry_in};
            end
            alu_and: begin
                sum = {1'b0, op1 & op2};
            end
            alu_xor: begin
                sum = {1'b0, op1 ^ op2};
            end
            default: begin
                sum = {1'b0, op1 | op2};
            end
        endcase
    end

    assign result = sum[7:0];

    assign is_sub   = (op == alu_sub) || (op == alu_sbc) || (op == alu_cp);
    assign is_arith = is_sub || (op == alu_add) || (op == alu_adc);

    // Signed overflow, operand signs compared against the result sign
    assign overflow = (is_sub ? (op1[7] != op2[7]) : (op1[7] == op2[7]))
                      && (sum[7] != op1[7]);

    // --------------------------------------------------
    // Flag byte
    // --------------------------------------------------

    always_comb begin
        flags_out = 8'h00;
        flags_out[flag_sf] = sum[7];
        flags_out[flag_zf] = (sum[7:0] == 8'h00);
        if (is_arith) begin
            flags_out[flag_af] = op1[4] ^ op2[4] ^ sum[4];
            flags_out[flag_pf] = overflow;
            flags_out[flag_nf] = is_sub;
            flags_out[flag_cf] = sum[8];
        end else begin
            // Even parity for the logic group
            flags_out[flag_pf] = ~^sum[7:0];
        end
    end

endmodule

// File: hw/kr580_pkg.sv
package kr580_pkg;

    // --------------------------------------------------
    // Word widths
    // --------------------------------------------------

    localparam int data_width = 8;
    localparam int addr_width = 16;

    typedef logic [data_width-1:0] byte_t;
    typedef logic [addr_width-1:0] addr_t;

    // Register number in opcode field order
    typedef logic [2:0] reg_sel_t;

    // Register pair number, BC DE HL SP
    typedef logic [1:0] pair_sel_t;

    localparam reg_sel_t reg_b = 3'd0;
    localparam reg_sel_t reg_c = 3'd1;
    localparam reg_sel_t reg_d = 3'd2;
    localparam reg_sel_t reg_e = 3'd3;
    localparam reg_sel_t reg_h = 3'd4;
    localparam reg_sel_t reg_l = 3'd5;
    localparam reg_sel_t reg_m = 3'd6;
    localparam reg_sel_t reg_a = 3'd7;

    // --------------------------------------------------
    // ALU and flags
    // --------------------------------------------------

    typedef enum logic [2:0] {
        alu_add,
        alu_adc,
        alu_sub,
        alu_sbc,
        alu_and,
        alu_xor,
        alu_or,
        alu_cp
    } alu_op_t;

    localparam int flag_cf = 0;
    localparam int flag_nf = 1;
    localparam int flag_pf = 2;
    localparam int flag_af = 4;
    localparam int flag_zf = 6;
    localparam int flag_sf = 7;

    localparam byte_t reset_flags = 8'h01;

    // --------------------------------------------------
    // Sequencer and register file exchange
    // --------------------------------------------------

    typedef enum logic [1:0] {step_fetch, step_1, step_2, step_3} step_t;

    typedef struct packed {
        logic     byte_en;
        logic     pair_en;
        reg_sel_t sel;
        addr_t    data;
        logic     flag_en;
        byte_t    flags;
    } reg_wr_t;

    typedef struct packed {
        byte_t a;
        addr_t hl;
        byte_t flags;
        byte_t sel_byte;
    } reg_view_t;

endpackage

// File: hw/kr580_regfile.sv
`timescale 1ns/10ps

module kr580_regfile
    import kr580_pkg::*;
(
    input  logic      clock,
    input  logic      reset_n,
    input  logic      locked,
    input  reg_sel_t  rd_sel,
    input  reg_wr_t   wr,
    output reg_view_t view
);

    byte_t     b_q;
    byte_t     c_q;
    byte_t     d_q;
    byte_t     e_q;
    byte_t     h_q;
    byte_t     l_q;
    byte_t     a_q;
    addr_t     sp_q;
    byte_t     f_q;
    byte_t     sel_byte;
    pair_sel_t wr_pair;

    assign wr_pair = pair_sel_t'(wr.sel[1:0]);

    // --------------------------------------------------
    // Write ports
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            b_q  <= '0;
            c_q  <= '0;
            d_q  <= '0;
            e_q  <= '0;
            h_q  <= '0;
            l_q  <= '0;
            a_q  <= '0;
            sp_q <= '0;
            f_q  <= reset_flags;
        end else if (locked) begin
            if (wr.pair_en) begin
                case (wr_pair)
                    2'd0: {b_q, c_q} <= wr.data;
                    2'd1: {d_q, e_q} <= wr.data;
                    2'd2: {h_q, l_q} <= wr.data;
                    default: sp_q <= wr.data;
                endcase
            end else if (wr.byte_en) begin
                case (wr.sel)
                    reg_b: b_q <= wr.data[7:0];
                    reg_c: c_q <= wr.data[7:0];
                    reg_d: d_q <= wr.data[7:0];
                    reg_e: e_q <= wr.data[7:0];
                    reg_h: h_q <= wr.data[7:0];
                    reg_l: l_q <= wr.data[7:0];
                    reg_a: a_q <= wr.data[7:0];
                    // M lives in memory
                    default: ;
                endcase
            end
            if (wr.flag_en) begin
                f_q <= wr.flags;
            end
        end
    end

    // Read side
    always_comb begin
        case (rd_sel)
            reg_b:   sel_byte = b_q;
            reg_c:   sel_byte = c_q;
            reg_d:   sel_byte = d_q;
            reg_e:   sel_byte = e_q;
            reg_h:   sel_byte = h_q;
            reg_l:   sel_byte = l_q;
            reg_a:   sel_byte = a_q;
            default: sel_byte = 8'h00;
        endcase
    end

    assign view.a        = a_q;
    assign view.hl       = {h_q, l_q};
    assign view.flags    = f_q;
    assign view.sel_byte = sel_byte;

endmodule

// File: hw/kr580_sequencer.sv
`timescale 1ns/10ps

module kr580_sequencer
    import kr580_pkg::*;
(
    input  logic      clock,
    input  logic      reset_n,
    input  logic      locked,
    input  byte_t     in,
    input  reg_view_t view,
    input  byte_t     alu_result,
    input  byte_t     alu_flags,
    output addr_t     address,
    output byte_t     out,
    output logic      we,
    output logic      pw,
    output logic      halted,
    output reg_sel_t  rd_sel,
    output reg_wr_t   wr,
    output alu_op_t   alu_op,
    output byte_t     op1,
    output byte_t     op2
);

    step_t    step;
    step_t    step_d;
    addr_t    pc;
    addr_t    pc_d;
    addr_t    dar;
    addr_t    dar_d;
    byte_t    opcode;
    byte_t    tmp;
    byte_t    tmp_d;
    byte_t    op1_d;
    byte_t    op2_d;
    alu_op_t  op_d;
    logic     halt_d;
    logic     use_dar;
    logic     mem_wr;
    logic     port_wr;
    logic     cond_flag;
    logic     cond;
    byte_t    incdec_flags;
    reg_sel_t dst;
    reg_sel_t src;
    logic     dst_m;
    logic     src_m;
    logic     is_lxi;
    logic     is_mvi;
    logic     is_incdec;
    logic     is_mov;
    logic     is_alu_r;
    logic     is_alu_i;
    logic     is_alu;
    logic     is_lda;
    logic     is_sta;
    logic     is_jmp;
    logic     is_jcc;
    logic     is_abs;
    logic     is_out;

    // Opcodes that need more than the fetch step
    function automatic logic multi_step(input byte_t code);
        multi_step = (code[7:6] == 2'b00 && code[3:0] == 4'b0001)
                     || (code[7:6] == 2'b00 && code[2:1] == 2'b10)
                     || (code[7:6] == 2'b00 && code[2:0] == 3'b110)
                     || code == 8'h32 || code == 8'h3a
                     || (code[7:6] == 2'b01 && code != 8'h76)
                     || code[7:6] == 2'b10
                     || (code[7:6] == 2'b11 && code[2:0] == 3'b010)
                     || (code[7:6] == 2'b11 && code[2:0] == 3'b110)
                     || code == 8'hc3 || code == 8'hd3;
    endfunction

    // --------------------------------------------------
    // Decode of the latched opcode
    // --------------------------------------------------

    assign dst   = opcode[5:3];
    assign src   = opcode[2:0];
    assign dst_m = (dst == reg_m);
    assign src_m = (src == reg_m);

    assign is_lxi    = (opcode[7:6] == 2'b00) && (opcode[3:0] == 4'b0001);
    assign is_incdec = (opcode[7:6] == 2'b00) && (opcode[2:1] == 2'b10);
    assign is_mvi    = (opcode[7:6] == 2'b00) && (opcode[2:0] == 3'b110);
    assign is_mov    = (opcode[7:6] == 2'b01);
    assign is_alu_r  = (opcode[7:6] == 2'b10);
    assign is_alu_i  = (opcode[7:6] == 2'b11) && (opcode[2:0] == 3'b110);
    assign is_alu    = is_alu_r || is_alu_i;
    assign is_lda    = (opcode == 8'h3a);
    assign is_sta    = (opcode == 8'h32);
    assign is_jmp    = (opcode == 8'hc3);
    assign is_jcc    = (opcode[7:6] == 2'b11) && (opcode[2:0] == 3'b010);
    assign is_abs    = is_lda || is_sta || is_jmp || is_jcc;
    assign is_out    = (opcode == 8'hd3);

    // NZ Z, NC C, PO PE, P M
    always_comb begin
        case (opcode[5:4])
            2'b00:   cond_flag = view.flags[flag_zf];
            2'b01:   cond_flag = view.flags[flag_cf];
            2'b10:   cond_flag = view.flags[flag_pf];
            default: cond_flag = view.flags[flag_sf];
        endcase
    end

    assign cond = is_jmp || (cond_flag == opcode[3]);

    // INR and DCR keep the old carry
    always_comb begin
        incdec_flags = alu_flags;
        incdec_flags[flag_cf] = view.flags[flag_cf];
    end

    // Address select, kept apart from the data path so it never depends on in
    always_comb begin
        case (step)
            step_1:  use_dar = ((is_mov || is_alu_r) && src_m) || (is_incdec && dst_m);
            step_2:  use_dar = ((is_mvi || is_mov || is_incdec) && dst_m) || is_out;
            step_3:  use_dar = is_lda || is_sta;
            default: use_dar = 1'b0;
        endcase
    end

    assign address = use_dar ? dar : pc;
    assign we      = mem_wr && locked;
    assign pw      = port_wr && locked;

    // --------------------------------------------------
    // Step decode
    // --------------------------------------------------

    always_comb begin
        step_d  = step_fetch;
        pc_d    = pc;
        halt_d  = halted;
        dar_d   = dar;
        tmp_d   = tmp;
        op1_d   = op1;
        op2_d   = op2;
        op_d    = alu_op;
        mem_wr  = 1'b0;
        port_wr = 1'b0;
        out     = view.a;
        rd_sel  = src;
        wr      = '0;

        case (step)
            step_fetch: begin
                pc_d  = pc + 16'd1;
                dar_d = view.hl;
                if (in == 8'h76) begin
                    halt_d = 1'b1;
                end
                if (multi_step(in)) begin
                    step_d = step_1;
                end
            end
            step_1: begin
                step_d = step_2;
                if (is_mvi) begin
                    pc_d  = pc + 16'd1;
                    tmp_d = in;
                    if (!dst_m) begin
                        wr.byte_en = 1'b1;
                        wr.sel     = dst;
                        wr.data    = {8'h00, in};
                        step_d     = step_fetch;
                    end
                end else if (is_mov) begin
                    tmp_d = src_m ? in : view.sel_byte;
                    if (!src_m && !dst_m) begin
                        wr.byte_en = 1'b1;
                        wr.sel     = dst;
                        wr.data    = {8'h00, view.sel_byte};
                        step_d     = step_fetch;
                    end
                end else if (is_incdec) begin
                    rd_sel = dst;
                    op1_d  = dst_m ? in : view.sel_byte;
                    op2_d  = 8'h01;
                    op_d   = opcode[0] ? alu_sub : alu_add;
                end else if (is_alu) begin
                    op1_d = view.a;
                    op_d  = alu_op_t'(opcode[5:3]);
                    if (is_alu_i) begin
                        op2_d = in;
                        pc_d  = pc + 16'd1;
                    end else begin
                        op2_d = src_m ? in : view.sel_byte;
                    end
                end else begin
                    // First operand byte of LXI, the a16 forms and OUT
                    pc_d  = pc + 16'd1;
                    tmp_d = in;
                    dar_d = {8'h00, in};
                end
            end
            step_2: begin
                if (is_mvi || is_mov) begin
                    if (dst_m) begin
                        mem_wr = 1'b1;
                        out    = tmp;
                    end else begin
                        wr.byte_en = 1'b1;
                        wr.sel     = dst;
                        wr.data    = {8'h00, tmp};
                    end
                end else if (is_incdec) begin
                    if (dst_m) begin
                        mem_wr = 1'b1;
                        out    = alu_result;
                        step_d = step_3;
                    end else begin
                        wr.byte_en = 1'b1;
                        wr.sel     = dst;
                        wr.data    = {8'h00, alu_result};
                        wr.flag_en = 1'b1;
                        wr.flags   = incdec_flags;
                    end
                end else if (is_alu) begin
                    // CP only updates flags
                    wr.byte_en = (alu_op != alu_cp);
                    wr.sel     = reg_a;
                    wr.data    = {8'h00, alu_result};
                    wr.flag_en = 1'b1;
                    wr.flags   = alu_flags;
                end else if (is_lxi) begin
                    pc_d       = pc + 16'd1;
                    wr.pair_en = 1'b1;
                    wr.sel     = reg_sel_t'({1'b0, opcode[5:4]});
                    wr.data    = {in, tmp};
                end else if (is_abs) begin
                    pc_d   = pc + 16'd1;
                    dar_d  = {in, tmp};
                    step_d = step_3;
                end else if (is_out) begin
                    port_wr = 1'b1;
                end
            end
            default: begin
                if (is_incdec) begin
                    wr.flag_en = 1'b1;
                    wr.flags   = incdec_flags;
                end else if (is_lda) begin
                    wr.byte_en = 1'b1;
                    wr.sel     = reg_a;
                    wr.data    = {8'h00, in};
                end else if (is_sta) begin
                    mem_wr = 1'b1;
                end else if (cond) begin
                    pc_d = dar;
                end
            end
        endcase
    end

    // --------------------------------------------------
    // State registers
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            step   <= step_fetch;
            pc     <= '0;
            halted <= 1'b0;
        end else if (locked && !halted) begin
            step   <= step_d;
            pc     <= pc_d;
            halted <= halt_d;
        end
    end

    // Opcode, address and operand latches
    always_ff @(posedge clock) begin
        if (locked && !halted) begin
            if (step == step_fetch) begin
                opcode <= in;
            end
            dar    <= dar_d;
            tmp    <= tmp_d;
            op1    <= op1_d;
            op2    <= op2_d;
            alu_op <= op_d;
        end
    end

endmodule

// File: hw/kr580_top.sv
`timescale 1ns/10ps

module kr580_top
    import kr580_pkg::*;
(
    input  logic  clock,
    input  logic  reset_n,
    input  logic  locked,
    input  byte_t in,
    output addr_t address,
    output byte_t out,
    output logic  we,
    output logic  pw,
    output logic  halted
);

    reg_sel_t  rd_sel;
    reg_wr_t   wr;
    reg_view_t view;
    alu_op_t   alu_op;
    byte_t     op1;
    byte_t     op2;
    byte_t     alu_result;
    byte_t     alu_flags;

    kr580_sequencer sequencer_i (
        .clock      (clock),
        .reset_n    (reset_n),
        .locked     (locked),
        .in         (in),
        .view       (view),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .address    (address),
        .out        (out),
        .we         (we),
        .pw         (pw),
        .halted     (halted),
        .rd_sel     (rd_sel),
        .wr         (wr),
        .alu_op     (alu_op),
        .op1        (op1),
        .op2        (op2)
    );

    kr580_regfile regfile_i (
        .clock   (clock),
        .reset_n (reset_n),
        .locked  (locked),
        .rd_sel  (rd_sel),
        .wr      (wr),
        .view    (view)
    );

    // Carry in comes from the live flag byte
    kr580_alu alu_i (
        .op        (alu_op),
        .op1       (op1),
        .op2       (op2),
        .flags_in  (view.flags),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

endmodule

// File: tb/kr580_tb_cases.svh
// Test program table, one row per case
localparam int max_cases = 40;

logic [7:0]  prog [max_cases][16];
logic [23:0] wr_exp [max_cases][8];
logic [23:0] pw_exp [max_cases][4];
int          wr_count [max_cases];
int          pw_count [max_cases];
logic        stall_case [max_cases];
int          num_cases = 0;
int          gen_pos;

task automatic start_case();
    wr_count[num_cases] = 0;
    pw_count[num_cases] = 0;
    gen_pos = 0;
    for (int i = 0; i < 16; i++) begin
        prog[num_cases][i] = 8'h00;
    end
endtask

// Byte 0 of the program is the leftmost byte of the vector
task automatic set_program(input logic [127:0] bytes);
    start_case();
    for (int i = 0; i < 16; i++) begin
        prog[num_cases][i] = bytes[127 - 8 * i -: 8];
    end
endtask

task automatic emit(input logic [7:0] value);
    prog[num_cases][gen_pos] = value;
    gen_pos++;
endtask

task automatic add_write(input logic [15:0] addr, input logic [7:0] data);
    wr_exp[num_cases][wr_count[num_cases]] = {addr, data};
    wr_count[num_cases]++;
endtask

task automatic add_port(input logic [7:0] port, input logic [7:0] data);
    pw_exp[num_cases][pw_count[num_cases]] = {8'h00, port, data};
    pw_count[num_cases]++;
endtask

task automatic end_case(input logic stall);
    stall_case[num_cases] = stall;
    num_cases++;
endtask

// --------------------------------------------------
// Fixed rows, the first two repeated with stalls
// --------------------------------------------------
task automatic load_fixed_cases();
    for (int s = 0; s < 2; s++) begin
        // LXI H, MVI M, MOV B,M, MOV A,B, STA, MVI C, MOV M,C, HLT
        set_program(128'h21_20_01_36_5a_46_78_32_30_01_0e_3c_71_76_00_00);
        add_write(16'h0120, 8'h5a);
        add_write(16'h0130, 8'h5a);
        add_write(16'h0120, 8'h3c);
        end_case(s == 1);
        // LDA of byte 15, JMP over an STA, OUT, STA, HLT
        set_program(128'h3a_0f_00_c3_09_00_32_40_01_d3_42_32_41_01_76_a7);
        add_port(8'h42, 8'ha7);
        add_write(16'h0141, 8'ha7);
        end_case(s == 1);
    end
    // LXI B and LXI D seen through MOV and STA
    set_program(128'h01_34_12_78_32_70_01_11_cd_ab_7b_32_71_01_76_00);
    add_write(16'h0170, 8'h12);
    add_write(16'h0171, 8'hcd);
    end_case(1'b0);
    // INR M twice then DCR M
    set_program(128'h21_90_01_34_34_35_76_00_00_00_00_00_00_00_00_00);
    add_write(16'h0190, 8'h01);
    add_write(16'h0190, 8'h02);
    add_write(16'h0190, 8'h01);
    end_case(1'b0);
endtask

// File: tb/kr580_tb.sv
`timescale 1ns/10ps

module kr580_tb
    import kr580_pkg::*;
();

    logic  clock = 1'b0;
    logic  reset_n = 1'b0;
    logic  locked = 1'b1;
    byte_t in;
    addr_t address;
    byte_t out;
    logic  we;
    logic  pw;
    logic  halted;

    logic [7:0]  mem [0:65535];
    logic [23:0] wr_log [$];
    logic [23:0] pw_log [$];
    int          errors = 0;
    logic        stall_enable = 1'b0;
    int          stall_left = 0;
    logic [31:0] gen_state = 32'he097_efe7;
    logic [31:0] stall_state = 32'he097_efe7;

    `include "kr580_tb_cases.svh"

    kr580_top dut_i (
        .clock   (clock),
        .reset_n (reset_n),
        .locked  (locked),
        .in      (in),
        .address (address),
        .out     (out),
        .we      (we),
        .pw      (pw),
        .halted  (halted)
    );

    assign in = mem[address];

    always #5 clock = ~clock;

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    task automatic take_bits(input int n, inout logic [31:0] state, output logic [31:0] value);
        logic fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = state[31] ^ state[21] ^ state[1] ^ state[0];
            state = {state[30:0], fb};
            value = {value[30:0], fb};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Reference model of the accumulator ALU returning flags and result
    function automatic logic [15:0] alu_model(input logic [2:0] op, input logic [7:0] a,
                                              input logic [7:0] b, input logic cin);
        logic [8:0] r;
        logic [7:0] f;
        logic       sub;
        int         sa;
        int         sb;
        int         sv;
        case (op)
            3'd0:    r = {1'b0, a} + {1'b0, b};
            3'd1:    r = {1'b0, a} + {1'b0, b} + {8'h00, cin};
            3'd3:    r = {1'b0, a} - {1'b0, b} - {8'h00, cin};
            3'd4:    r = {1'b0, a & b};
            3'd5:    r = {1'b0, a ^ b};
            3'd6:    r = {1'b0, a | b};
            default: r = {1'b0, a} - {1'b0, b};
        endcase
        sub = (op == 3'd2) || (op == 3'd3) || (op == 3'd7);
        sa = int'($signed(a));
        sb = int'($signed(b));
        f = 8'h00;
        f[7] = r[7];
        f[6] = (r[7:0] == 8'h00);
        if (op < 3'd4 || op == 3'd7) begin
            // Signed result outside the byte range is overflow
            sv = sub ? sa - sb : sa + sb;
            if (op == 3'd1) begin
                sv = sv + int'(cin);
            end else if (op == 3'd3) begin
                sv = sv - int'(cin);
            end
            f[4] = a[4] ^ b[4] ^ r[4];
            f[2] = (sv > 127) || (sv < -128);
            f[1] = sub;
            f[0] = r[8];
        end else begin
            f[2] = ~^r[7:0];
        end
        return {f, r[7:0]};
    endfunction

    // NZ Z NC C PO PE P M
    function automatic logic cond_taken(input logic [2:0] j, input logic [7:0] f);
        logic flag;
        case (j[2:1])
            2'd0:    flag = f[6];
            2'd1:    flag = f[0];
            2'd2:    flag = f[2];
            default: flag = f[7];
        endcase
        return flag == j[0];
    endfunction

    // --------------------------------------------------
    // Generated ALU, INR and DCR rows
    // --------------------------------------------------
    task automatic build_alu_cases();
        logic [31:0] r;
        logic [7:0]  a;
        logic [7:0]  b;
        logic [2:0]  j;
        logic [2:0]  op;
        logic [15:0] res;
        logic [7:0]  flags;
        logic [7:0]  a_new;
        int          form;
        for (int i = 0; i < 28; i++) begin
            take_bits(8, gen_state, r);
            a = r[7:0];
            take_bits(8, gen_state, r);
            b = r[7:0];
            take_bits(3, gen_state, r);
            j = r[2:0];
            form = (i < 24) ? i / 8 : 3;
            op = (i < 24) ? 3'(i) : ((i % 2 == 1) ? 3'd2 : 3'd0);
            start_case();
            emit(8'h3e);
            emit(a);
            case (form)
                0: begin
                    emit(8'h06);
                    emit(b);
                    emit({2'b10, op, 3'b000});
                end
                1: begin
                    // HL points at byte 15
                    emit(8'h2e);
                    emit(8'h0f);
                    emit({2'b10, op, 3'b110});
                    prog[num_cases][15] = b;
                end
                2: begin
                    emit({2'b11, op, 3'b110});
                    emit(b);
                end
                default: begin
                    b = 8'h01;
                    emit((op == 3'd2) ? 8'h3d : 8'h3c);
                end
            endcase
            // Carry is set after reset
            res = alu_model(op, a, b, 1'b1);
            flags = res[15:8];
            if (form == 3) begin
                flags[0] = 1'b1;
            end
            a_new = (op == 3'd7) ? a : res[7:0];
            emit(8'h32);
            emit(8'h50);
            emit(8'h01);
            add_write(16'h0150, a_new);
            emit({2'b11, j, 3'b010});
            emit(8'(gen_pos + 3));
            emit(8'h00);
            emit(8'h76);
            emit(8'hd3);
            emit(8'h01);
            emit(8'h76);
            if (cond_taken(j, flags)) begin
                add_port(8'h01, a_new);
            end
            end_case(1'b0);
        end
    endtask

    // Stretches of locked low
    always @(negedge clock) begin
        logic [31:0] r;
        if (!stall_enable) begin
            locked = 1'b1;
            stall_left = 0;
        end else if (stall_left != 0) begin
            locked = 1'b0;
            stall_left--;
        end else begin
            locked = 1'b1;
            take_bits(2, stall_state, r);
            if (r[1:0] == 2'b00) begin
                take_bits(3, stall_state, r);
                stall_left = int'(r[2:0]) + 1;
            end
        end
    end

    // One clock with memory write, logging and strobe check
    task automatic tick();
        @(posedge clock);
        if (we) begin
            mem[address] <= out;
            wr_log.push_back({address, out});
        end
        if (pw) begin
            pw_log.push_back({address, out});
        end
        if (!locked && (we || pw)) begin
            $display("strobe seen while locked is low at %0t", $time);
            errors++;
        end
    endtask

    task automatic run_case(input int k);
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'h00;
        end
        for (int i = 0; i < 16; i++) begin
            mem[i] = prog[k][i];
        end
        @(negedge clock);
        reset_n = 1'b0;
        repeat (16) tick();
        @(negedge clock);
        check_value("we", {31'h0, we}, 32'h0);
        check_value("pw", {31'h0, pw}, 32'h0);
        check_value("halted", {31'h0, halted}, 32'h0);
        wr_log.delete();
        pw_log.delete();
        reset_n = 1'b1;
        tick();
        stall_enable = stall_case[k];
        while (!halted) begin
            tick();
        end
        // Nothing may follow HLT
        repeat (8) tick();
        stall_enable = 1'b0;
        check_value("write count", wr_log.size(), wr_count[k]);
        for (int i = 0; i < wr_log.size() && i < wr_count[k]; i++) begin
            check_value("write address", {16'h0, wr_log[i][23:8]}, {16'h0, wr_exp[k][i][23:8]});
            check_value("write data", {24'h0, wr_log[i][7:0]}, {24'h0, wr_exp[k][i][7:0]});
        end
        check_value("port write count", pw_log.size(), pw_count[k]);
        for (int i = 0; i < pw_log.size() && i < pw_count[k]; i++) begin
            check_value("port address", {16'h0, pw_log[i][23:8]}, {16'h0, pw_exp[k][i][23:8]});
            check_value("port data", {24'h0, pw_log[i][7:0]}, {24'h0, pw_exp[k][i][7:0]});
        end
    endtask

    initial begin
        load_fixed_cases();
        build_alu_cases();
        for (int k = 0; k < num_cases; k++) begin
            run_case(k);
        end
        $display("%0d errors in %0d cases", errors, num_cases);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #1;
        #((num_cases * 230 + 16) * 10);
        $display("watchdog expired, the core did not reach HLT in time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule
